// ==== rtl/ccip_chk_pkg.sv ====
// CCI-P protocol checker shared definitions
// Field widths, request and length encodings, error vector layout
package ccip_chk_pkg;

   // Field widths
   localparam int CL_ADDR_WIDTH  = 42;
   localparam int MDATA_WIDTH    = 16;
   localparam int TID_WIDTH      = 9;
   localparam int REQ_TYPE_WIDTH = 4;
   localparam int ERR_VEC_WIDTH  = 32;

   // Line count of a request, 3 lines is illegal
   typedef enum logic [1:0] {
      CL_LEN_1 = 2'd0,
      CL_LEN_2 = 2'd1,
      CL_LEN_3 = 2'd2,
      CL_LEN_4 = 2'd3
   } t_cl_len;

   // Channel 0 reads, every other code is illegal
   typedef enum logic [REQ_TYPE_WIDTH-1:0] {
      RDLINE_I = 4'h0,
      RDLINE_S = 4'h1
   } t_c0_req;

   // Channel 1 writes and the write fence
   typedef enum logic [REQ_TYPE_WIDTH-1:0] {
      WRLINE_I = 4'h0,
      WRLINE_M = 4'h1,
      WRPUSH_I = 4'h2,
      WRFENCE  = 4'h4
   } t_c1_req;

   // Bit positions in the error vector
   typedef enum int {
      C0_INVALID_REQTYPE = 0,
      C0_OVERFLOW        = 1,
      C0_ALIGN2          = 2,
      C0_ALIGN4          = 3,
      C0_RESET_IGNORED   = 4,
      C0_3CL             = 5,
      C0_ADDR_ZERO       = 6,
      C1_INVALID_REQTYPE = 7,
      C1_OVERFLOW        = 8,
      C1_ALIGN2          = 9,
      C1_ALIGN4          = 10,
      C1_RESET_IGNORED   = 11,
      C1_UNEXP_VCSEL     = 12,
      C1_UNEXP_MDATA     = 13,
      C1_UNEXP_ADDR      = 14,
      C1_UNEXP_CLLEN     = 15,
      C1_UNEXP_REQTYPE   = 16,
      C1_SOP_NOT_SET     = 17,
      C1_SOP_SET_MCL     = 18,
      C1_3CL             = 19,
      C1_WRFENCE_IN_MCL  = 20,
      C1_WRFENCE_SOP     = 21,
      C1_ADDR_ZERO       = 22,
      MMIO_TIMEOUT       = 23,
      MMIO_UNSOLICITED   = 24,
      MMIO_RESET_IGNORED = 25
   } t_err_bit;

   // Slice owned by each checker
   localparam int C0_ERR_LO   = int'(C0_INVALID_REQTYPE);
   localparam int C0_ERR_HI   = int'(C0_ADDR_ZERO);
   localparam int C1_ERR_LO   = int'(C1_INVALID_REQTYPE);
   localparam int C1_ERR_HI   = int'(C1_ADDR_ZERO);
   localparam int MMIO_ERR_LO = int'(MMIO_TIMEOUT);
   localparam int MMIO_ERR_HI = int'(MMIO_RESET_IGNORED);

endpackage

// ==== rtl/c0_read_checker.sv ====
// Channel 0 read request checker
// Flags illegal types, bad lengths, misalignment and overflow per beat
`timescale 1ns/10ps

module c0_read_checker (
   input  logic                                          clk,
   input  logic                                          ase_reset,
   input  logic                                          soft_reset,
   input  logic                                          valid,
   input  ccip_chk_pkg::t_c0_req                         req_type,
   input  ccip_chk_pkg::t_cl_len                         cl_len,
   input  logic [ccip_chk_pkg::CL_ADDR_WIDTH-1:0]        address,
   input  logic                                          realfull,
   output logic [ccip_chk_pkg::C0_ERR_HI-ccip_chk_pkg::C0_ERR_LO:0] err
);
   import ccip_chk_pkg::*;

   logic                         rd_beat;
   logic [C0_ERR_HI-C0_ERR_LO:0] err_d;

   // Only legal reads get the length and address rules
   assign rd_beat = valid & (req_type inside {RDLINE_I, RDLINE_S});

   always_comb begin
      err_d = '0;
      // Type and flow rules apply to any valid beat
      err_d[C0_INVALID_REQTYPE - C0_ERR_LO] = valid & ~rd_beat;
      err_d[C0_OVERFLOW - C0_ERR_LO]        = valid & realfull;
      err_d[C0_RESET_IGNORED - C0_ERR_LO]   = valid & soft_reset;
      // 3 lines is never a legal read length
      err_d[C0_3CL - C0_ERR_LO]             = rd_beat & (cl_len == CL_LEN_3);
      // Multi-line reads start on a 2 or 4 line boundary
      err_d[C0_ALIGN2 - C0_ERR_LO]          = rd_beat & (cl_len == CL_LEN_2) & address[0];
      err_d[C0_ALIGN4 - C0_ERR_LO]          = rd_beat & (cl_len == CL_LEN_4) &
                                              (address[1:0] != 2'b00);
      // Warning only, address zero is almost always a bug in the AFU
      err_d[C0_ADDR_ZERO - C0_ERR_LO]       = rd_beat & (address == '0);
   end

   // One cycle after the sampling edge
   always_ff @(posedge clk) begin
      if (ase_reset) begin
         err <= '0;
      end else begin
         err <= err_d;
      end
   end

endmodule

// ==== rtl/c1_write_checker.sv ====
// Channel 1 write request checker
// Tracks multi-line write bursts beat by beat and flags header rule breaks
// First beats are checked for SOP, length and alignment, later beats
// against the header captured on the first beat
`timescale 1ns/10ps

module c1_write_checker (
   input  logic                                          clk,
   input  logic                                          ase_reset,
   input  logic                                          soft_reset,
   input  logic                                          valid,
   input  logic                                          sop,
   input  ccip_chk_pkg::t_c1_req                         req_type,
   input  ccip_chk_pkg::t_cl_len                         cl_len,
   input  logic [1:0]                                    vc_sel,
   input  logic [ccip_chk_pkg::CL_ADDR_WIDTH-1:0]        address,
   input  logic [ccip_chk_pkg::MDATA_WIDTH-1:0]          mdata,
   input  logic                                          realfull,
   output logic [ccip_chk_pkg::C1_ERR_HI-ccip_chk_pkg::C1_ERR_LO:0] err
);
   import ccip_chk_pkg::*;

   // Idle waits for a first beat, ST_BEAT expects beat beat_idx of a burst
   typedef enum logic {
      ST_IDLE,
      ST_BEAT
   } t_state;

   t_state                       state;
   logic [1:0]                   beat_idx;

   // Header of the first beat
   logic [1:0]                   base_addr_lo;
   logic [1:0]                   base_vc;
   t_cl_len                      base_len;
   logic [MDATA_WIDTH-1:0]       base_mdata;
   t_c1_req                      base_req;

   logic                         is_write;
   logic                         is_fence;
   logic                         fence_beat;
   logic                         first_beat;
   logic                         later_beat;
   logic                         start_mcl;
   logic                         last_beat;
   logic [1:0]                   exp_addr_lo;
   logic [C1_ERR_HI-C1_ERR_LO:0] err_d;

   // Request decode
   assign is_fence   = (req_type == WRFENCE);
   assign is_write   = req_type inside {WRLINE_I, WRLINE_M, WRPUSH_I};
   assign fence_beat = valid & is_fence;

   // Write beats split by tracker state
   assign first_beat = valid & is_write & (state == ST_IDLE);
   assign later_beat = valid & is_write & (state == ST_BEAT);

   // Only 2 and 4 line bursts have later beats
   assign start_mcl  = first_beat & sop & ((cl_len == CL_LEN_2) | (cl_len == CL_LEN_4));

   // Low address must step by one per beat
   assign exp_addr_lo = base_addr_lo + beat_idx;

   // Codes for 2 and 4 lines equal the index of the last beat
   assign last_beat   = later_beat & (beat_idx == 2'(base_len));

   // Beat tracker
   always_ff @(posedge clk) begin
      if (ase_reset || soft_reset) begin
         state    <= ST_IDLE;
         beat_idx <= 2'd0;
      end else if (start_mcl) begin
         state    <= ST_BEAT;
         beat_idx <= 2'd1;
      end else if (last_beat) begin
         state    <= ST_IDLE;
         beat_idx <= 2'd0;
      end else if (later_beat) begin
         beat_idx <= beat_idx + 2'd1;
      end
      // A fence mid-burst leaves the tracker where it is
   end

   // Capture the first beat of a burst
   always_ff @(posedge clk) begin
      if (start_mcl) begin
         base_addr_lo <= address[1:0];
         base_vc      <= vc_sel;
         base_len     <= cl_len;
         base_mdata   <= mdata;
         base_req     <= req_type;
      end
   end

   always_comb begin
      err_d = '0;

      // Any beat, any state
      err_d[C1_INVALID_REQTYPE - C1_ERR_LO] = valid & ~(is_write | is_fence);
      err_d[C1_OVERFLOW - C1_ERR_LO]        = valid & realfull;
      err_d[C1_RESET_IGNORED - C1_ERR_LO]   = valid & soft_reset;
      err_d[C1_WRFENCE_SOP - C1_ERR_LO]     = fence_beat & sop;

      // First beat of a write
      err_d[C1_SOP_NOT_SET - C1_ERR_LO]     = first_beat & ~sop;
      err_d[C1_3CL - C1_ERR_LO]             = first_beat & (cl_len == CL_LEN_3);
      err_d[C1_ALIGN2 - C1_ERR_LO]          = first_beat & (cl_len == CL_LEN_2) & address[0];
      err_d[C1_ALIGN4 - C1_ERR_LO]          = first_beat & (cl_len == CL_LEN_4) &
                                              (address[1:0] != 2'b00);
      // Warning only
      err_d[C1_ADDR_ZERO - C1_ERR_LO]       = first_beat & (address == '0);

      // Later beats must follow the captured header
      err_d[C1_UNEXP_ADDR - C1_ERR_LO]      = later_beat & (address[1:0] != exp_addr_lo);
      err_d[C1_SOP_SET_MCL - C1_ERR_LO]     = later_beat & sop;
      err_d[C1_UNEXP_VCSEL - C1_ERR_LO]     = later_beat & (vc_sel != base_vc);
      err_d[C1_UNEXP_MDATA - C1_ERR_LO]     = later_beat & (mdata != base_mdata);
      err_d[C1_UNEXP_CLLEN - C1_ERR_LO]     = later_beat & (cl_len != base_len);
      err_d[C1_UNEXP_REQTYPE - C1_ERR_LO]   = later_beat & (req_type != base_req);

      // Fence cannot split a burst
      err_d[C1_WRFENCE_IN_MCL - C1_ERR_LO]  = fence_beat & (state == ST_BEAT);
   end

   // Registered error slice
   always_ff @(posedge clk) begin
      if (ase_reset) begin
         err <= '0;
      end else begin
         err <= err_d;
      end
   end

endmodule

// ==== rtl/mmio_rsp_tracker.sv ====
// MMIO read response tracker
// One active flag and saturating timer per TID, flags timeouts,
// unsolicited responses and responses during soft reset
`timescale 1ns/10ps

module mmio_rsp_tracker #(
   parameter int MMIO_TIMEOUT = 512
) (
   input  logic                                  clk,
   input  logic                                  ase_reset,
   input  logic                                  soft_reset,
   input  logic                                  req_valid,
   input  logic [ccip_chk_pkg::TID_WIDTH-1:0]    req_tid,
   input  logic                                  rsp_valid,
   input  logic [ccip_chk_pkg::TID_WIDTH-1:0]    rsp_tid,
   output logic [ccip_chk_pkg::MMIO_ERR_HI-ccip_chk_pkg::MMIO_ERR_LO:0] err
);
   import ccip_chk_pkg::*;

   localparam int DEPTH = 2 ** TID_WIDTH;
   localparam int TMR_W = $clog2(MMIO_TIMEOUT + 1);

   logic [DEPTH-1:0] active;
   logic [TMR_W-1:0] timer [DEPTH];
   logic             any_timeout;

   // Entry update, request wins over a response to the same TID
   always_ff @(posedge clk) begin
      if (ase_reset || soft_reset) begin
         active <= '0;
         for (int i = 0; i < DEPTH; i++) begin
            timer[i] <= '0;
         end
      end else begin
         for (int i = 0; i < DEPTH; i++) begin
            if (req_valid && (req_tid == TID_WIDTH'(i))) begin
               active[i] <= 1'b1;
               timer[i]  <= '0;
            end else if (rsp_valid && (rsp_tid == TID_WIDTH'(i))) begin
               active[i] <= 1'b0;
               timer[i]  <= '0;
            end else if (active[i] && (timer[i] != TMR_W'(MMIO_TIMEOUT))) begin
               // Saturates at the limit
               timer[i]  <= timer[i] + TMR_W'(1);
            end
         end
      end
   end

   // Any entry sitting at the limit
   always_comb begin
      any_timeout = 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
         any_timeout = any_timeout | (active[i] & (timer[i] == TMR_W'(MMIO_TIMEOUT)));
      end
   end

   // Error bits one cycle after the sampling edge
   always_ff @(posedge clk) begin
      if (ase_reset) begin
         err <= '0;
      end else begin
         err[ccip_chk_pkg::MMIO_TIMEOUT - MMIO_ERR_LO] <= any_timeout;
         err[MMIO_UNSOLICITED - MMIO_ERR_LO]           <= rsp_valid & ~active[rsp_tid];
         err[MMIO_RESET_IGNORED - MMIO_ERR_LO]         <= rsp_valid & soft_reset;
      end
   end

endmodule

// ==== rtl/ccip_checker_top.sv ====
// CCI-P protocol checker top level
// Channel 0, channel 1 and MMIO checkers each fill one slice
// of the registered error vector, unused bits stay zero
`timescale 1ns/10ps

module ccip_checker_top #(
   parameter int MMIO_TIMEOUT = 512
) (
   input  logic                                    clk,
   input  logic                                    ase_reset,
   input  logic                                    soft_reset,
   // Channel 0 read requests
   input  logic                                    c0_valid,
   input  ccip_chk_pkg::t_c0_req                   c0_req_type,
   input  ccip_chk_pkg::t_cl_len                   c0_cl_len,
   input  logic [ccip_chk_pkg::CL_ADDR_WIDTH-1:0]  c0_address,
   input  logic                                    c0_realfull,
   // Channel 1 write requests
   input  logic                                    c1_valid,
   input  logic                                    c1_sop,
   input  ccip_chk_pkg::t_c1_req                   c1_req_type,
   input  ccip_chk_pkg::t_cl_len                   c1_cl_len,
   input  logic [1:0]                              c1_vc_sel,
   input  logic [ccip_chk_pkg::CL_ADDR_WIDTH-1:0]  c1_address,
   input  logic [ccip_chk_pkg::MDATA_WIDTH-1:0]    c1_mdata,
   input  logic                                    c1_realfull,
   // MMIO request in, response out
   input  logic                                    mmio_req_valid,
   input  logic [ccip_chk_pkg::TID_WIDTH-1:0]      mmio_req_tid,
   input  logic                                    mmio_rsp_valid,
   input  logic [ccip_chk_pkg::TID_WIDTH-1:0]      mmio_rsp_tid,
   output logic [ccip_chk_pkg::ERR_VEC_WIDTH-1:0]  error_code
);
   import ccip_chk_pkg::*;

   logic [C0_ERR_HI-C0_ERR_LO:0]     c0_err;
   logic [C1_ERR_HI-C1_ERR_LO:0]     c1_err;
   logic [MMIO_ERR_HI-MMIO_ERR_LO:0] mmio_err;

   c0_read_checker u_c0_chk (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .valid      (c0_valid),
      .req_type   (c0_req_type),
      .cl_len     (c0_cl_len),
      .address    (c0_address),
      .realfull   (c0_realfull),
      .err        (c0_err)
   );

   c1_write_checker u_c1_chk (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .valid      (c1_valid),
      .sop        (c1_sop),
      .req_type   (c1_req_type),
      .cl_len     (c1_cl_len),
      .vc_sel     (c1_vc_sel),
      .address    (c1_address),
      .mdata      (c1_mdata),
      .realfull   (c1_realfull),
      .err        (c1_err)
   );

   mmio_rsp_tracker #(
      .MMIO_TIMEOUT (MMIO_TIMEOUT)
   ) u_mmio_trk (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .req_valid  (mmio_req_valid),
      .req_tid    (mmio_req_tid),
      .rsp_valid  (mmio_rsp_valid),
      .rsp_tid    (mmio_rsp_tid),
      .err        (mmio_err)
   );

   // Slices are already registered in each checker
   assign error_code[C0_ERR_HI:C0_ERR_LO]                 = c0_err;
   assign error_code[C1_ERR_HI:C1_ERR_LO]                 = c1_err;
   assign error_code[MMIO_ERR_HI:MMIO_ERR_LO]             = mmio_err;
   // Reserved
   assign error_code[ERR_VEC_WIDTH-1:MMIO_ERR_HI+1]       = '0;

endmodule

// ==== tests/ccip_checker_sva.sv ====
// Concurrent assertions on the checker's error vector
// Reserved bits, reset value and fence handling outside a burst
`timescale 1ns/10ps

module ccip_checker_sva (
   input logic                                    clk,
   input logic                                    ase_reset,
   input logic                                    c1_valid,
   input logic [ccip_chk_pkg::REQ_TYPE_WIDTH-1:0] c1_req_type,
   input logic                                    c1_in_burst,
   input logic [ccip_chk_pkg::ERR_VEC_WIDTH-1:0]  error_code
);
   import ccip_chk_pkg::*;

   // Reserved bits never move
   a_reserved_zero: assert property (@(posedge clk) disable iff (ase_reset)
      error_code[ERR_VEC_WIDTH-1:MMIO_ERR_HI+1] == '0)
      else $error("reserved error bits set");

   a_reset_clear: assert property (@(posedge clk)
      ase_reset |=> (error_code == '0))
      else $error("error vector not cleared by reset");

   // Fence in idle is legal
   a_idle_fence: assert property (@(posedge clk) disable iff (ase_reset)
      (c1_valid && (c1_req_type == WRFENCE) && !c1_in_burst)
         |=> !error_code[C1_WRFENCE_IN_MCL])
      else $error("fence outside a burst flagged as mid-burst");

endmodule

bind ccip_checker_top ccip_checker_sva u_sva (
   .clk         (clk),
   .ase_reset   (ase_reset),
   .c1_valid    (c1_valid),
   .c1_req_type (c1_req_type),
   .c1_in_burst (u_c1_chk.state),
   .error_code  (error_code)
);

// ==== tests/tb_ccip_checker.sv ====
// Testbench for the CCI-P protocol checker
// Directed tests on channel 0 reads, channel 1 writes and MMIO responses
`timescale 1ns/10ps

module tb_ccip_checker;
   import ccip_chk_pkg::*;

   localparam int clk_period    = 40;
   localparam int tmo_cycles    = 16;
   localparam int test_cycles   = 100;
   localparam int margin_cycles = 300;

   logic                      clk;
   logic                      ase_reset;
   logic                      soft_reset;
   logic                      c0_valid;
   t_c0_req                   c0_req_type;
   t_cl_len                   c0_cl_len;
   logic [CL_ADDR_WIDTH-1:0]  c0_address;
   logic                      c0_realfull;
   logic                      c1_valid;
   logic                      c1_sop;
   t_c1_req                   c1_req_type;
   t_cl_len                   c1_cl_len;
   logic [1:0]                c1_vc_sel;
   logic [CL_ADDR_WIDTH-1:0]  c1_address;
   logic [MDATA_WIDTH-1:0]    c1_mdata;
   logic                      c1_realfull;
   logic                      mmio_req_valid;
   logic [TID_WIDTH-1:0]      mmio_req_tid;
   logic                      mmio_rsp_valid;
   logic [TID_WIDTH-1:0]      mmio_rsp_tid;
   logic [ERR_VEC_WIDTH-1:0]  error_code;

   integer                    seed;
   int                        err_count;
   int                        test_count;
   int                        test_start_errs;
   // Base of the current 4-line burst
   logic [CL_ADDR_WIDTH-1:0]  b_addr;
   logic [MDATA_WIDTH-1:0]    b_mdata;

   ccip_checker_top #(
      .MMIO_TIMEOUT (tmo_cycles)
   ) uut (
      .clk            (clk),
      .ase_reset      (ase_reset),
      .soft_reset     (soft_reset),
      .c0_valid       (c0_valid),
      .c0_req_type    (c0_req_type),
      .c0_cl_len      (c0_cl_len),
      .c0_address     (c0_address),
      .c0_realfull    (c0_realfull),
      .c1_valid       (c1_valid),
      .c1_sop         (c1_sop),
      .c1_req_type    (c1_req_type),
      .c1_cl_len      (c1_cl_len),
      .c1_vc_sel      (c1_vc_sel),
      .c1_address     (c1_address),
      .c1_mdata       (c1_mdata),
      .c1_realfull    (c1_realfull),
      .mmio_req_valid (mmio_req_valid),
      .mmio_req_tid   (mmio_req_tid),
      .mmio_rsp_valid (mmio_rsp_valid),
      .mmio_rsp_tid   (mmio_rsp_tid),
      .error_code     (error_code)
   );

   always #(clk_period / 2) clk = ~clk;

   // Bit 2 set keeps the address nonzero, low bits stay random
   function automatic logic [CL_ADDR_WIDTH-1:0] rand_addr();
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      r[2] = 1'b1;
      return r[CL_ADDR_WIDTH-1:0];
   endfunction

   function automatic logic [MDATA_WIDTH-1:0] rand_mdata();
      logic [31:0] r;
      r = $random(seed);
      return r[MDATA_WIDTH-1:0];
   endfunction

   // Address of a given beat of the current burst
   function automatic logic [CL_ADDR_WIDTH-1:0] burst_addr(input int beat);
      return b_addr + CL_ADDR_WIDTH'(beat);
   endfunction

   // One-hot expected vector
   function automatic logic [ERR_VEC_WIDTH-1:0] err_bit(input int pos);
      return 32'd1 << pos;
   endfunction

   task automatic check_vec(input string name, input logic [ERR_VEC_WIDTH-1:0] exp,
                            input logic [ERR_VEC_WIDTH-1:0] act);
      if (exp !== act) begin
         $display("Error: %s expected %h got %h at %0t", name, exp, act, $time);
         err_count++;
      end
   endtask

   // Edge samples the beat, next falling edge sees the registered result
   task automatic step_cycle();
      @(posedge clk);
      @(negedge clk);
      c0_valid       = 1'b0;
      c1_valid       = 1'b0;
      mmio_req_valid = 1'b0;
      mmio_rsp_valid = 1'b0;
      c0_realfull    = 1'b0;
      c1_realfull    = 1'b0;
      soft_reset     = 1'b0;
   endtask

   task automatic idle_cycle(input logic [ERR_VEC_WIDTH-1:0] exp);
      step_cycle();
      check_vec("error_code", exp, error_code);
   endtask

   task automatic c0_read(input t_c0_req rt, input t_cl_len len,
                          input logic [CL_ADDR_WIDTH-1:0] a,
                          input logic [ERR_VEC_WIDTH-1:0] exp);
      c0_valid    = 1'b1;
      c0_req_type = rt;
      c0_cl_len   = len;
      c0_address  = a;
      idle_cycle(exp);
   endtask

   task automatic c1_write(input logic sop, input t_c1_req rt, input t_cl_len len,
                           input logic [1:0] vc, input logic [CL_ADDR_WIDTH-1:0] a,
                           input logic [MDATA_WIDTH-1:0] md,
                           input logic [ERR_VEC_WIDTH-1:0] exp);
      c1_valid    = 1'b1;
      c1_sop      = sop;
      c1_req_type = rt;
      c1_cl_len   = len;
      c1_vc_sel   = vc;
      c1_address  = a;
      c1_mdata    = md;
      idle_cycle(exp);
   endtask

   task automatic mmio_cycle(input logic req_v, input logic [TID_WIDTH-1:0] req_t,
                             input logic rsp_v, input logic [TID_WIDTH-1:0] rsp_t,
                             input logic [ERR_VEC_WIDTH-1:0] exp);
      mmio_req_valid = req_v;
      mmio_req_tid   = req_t;
      mmio_rsp_valid = rsp_v;
      mmio_rsp_tid   = rsp_t;
      idle_cycle(exp);
   endtask

   // First beat of a legal 4-line write
   task automatic burst_head();
      b_addr       = rand_addr();
      b_addr[1:0]  = 2'b00;
      b_mdata      = rand_mdata();
      c1_write(1'b1, WRLINE_M, CL_LEN_4, 2'd1, b_addr, b_mdata, '0);
   endtask

   // Soft reset puts the write tracker back to idle
   task automatic flush_tracker();
      soft_reset = 1'b1;
      idle_cycle('0);
   endtask

   task automatic begin_test();
      test_start_errs = err_count;
   endtask

   task automatic end_test(input string name);
      test_count++;
      $display("%s finished with %0d errors", name, err_count - test_start_errs);
   endtask

   task automatic test_c0_reads();
      logic [CL_ADDR_WIDTH-1:0] a;
      begin_test();
      for (int i = 0; i < 4; i++) begin
         c0_read((i % 2 == 0) ? RDLINE_I : RDLINE_S, CL_LEN_1, rand_addr(), '0);
      end
      c0_read(t_c0_req'(4'h5), CL_LEN_1, rand_addr(), err_bit(C0_INVALID_REQTYPE));
      a = rand_addr();
      a[1:0] = 2'b00;
      c0_read(RDLINE_I, CL_LEN_3, a, err_bit(C0_3CL));
      a[0] = 1'b1;
      c0_read(RDLINE_S, CL_LEN_2, a, err_bit(C0_ALIGN2));
      a[1:0] = 2'b10;
      c0_read(RDLINE_I, CL_LEN_4, a, err_bit(C0_ALIGN4));
      c0_read(RDLINE_S, CL_LEN_1, '0, err_bit(C0_ADDR_ZERO));
      c0_realfull = 1'b1;
      c0_read(RDLINE_I, CL_LEN_1, rand_addr(), err_bit(C0_OVERFLOW));
      soft_reset = 1'b1;
      c0_read(RDLINE_I, CL_LEN_1, rand_addr(), err_bit(C0_RESET_IGNORED));
      end_test("c0_reads");
   endtask

   task automatic test_c1_legal();
      logic [CL_ADDR_WIDTH-1:0] a;
      logic [MDATA_WIDTH-1:0]   md;
      begin_test();
      a = rand_addr();
      a[1:0] = 2'b00;
      md = rand_mdata();
      for (int i = 0; i < 4; i++) begin
         c1_write(i == 0, WRLINE_M, CL_LEN_4, 2'd1, a + CL_ADDR_WIDTH'(i), md, '0);
      end
      a = rand_addr();
      a[0] = 1'b0;
      md = rand_mdata();
      c1_write(1'b1, WRLINE_I, CL_LEN_2, 2'd2, a, md, '0);
      c1_write(1'b0, WRLINE_I, CL_LEN_2, 2'd2, a + CL_ADDR_WIDTH'(1), md, '0);
      // Fence alone in idle
      c1_write(1'b0, WRFENCE, CL_LEN_1, 2'd0, rand_addr(), '0, '0);
      end_test("c1_legal");
   endtask

   task automatic test_c1_burst_errors();
      begin_test();
      burst_head();
      c1_write(1'b0, WRLINE_M, CL_LEN_4, 2'd1, burst_addr(2), b_mdata, err_bit(C1_UNEXP_ADDR));
      flush_tracker();
      burst_head();
      c1_write(1'b0, WRLINE_M, CL_LEN_4, 2'd1, burst_addr(1), b_mdata ^ 16'h0001,
               err_bit(C1_UNEXP_MDATA));
      flush_tracker();
      burst_head();
      c1_write(1'b0, WRLINE_M, CL_LEN_4, 2'd3, burst_addr(1), b_mdata, err_bit(C1_UNEXP_VCSEL));
      flush_tracker();
      burst_head();
      c1_write(1'b0, WRLINE_M, CL_LEN_2, 2'd1, burst_addr(1), b_mdata, err_bit(C1_UNEXP_CLLEN));
      flush_tracker();
      burst_head();
      c1_write(1'b0, WRPUSH_I, CL_LEN_4, 2'd1, burst_addr(1), b_mdata,
               err_bit(C1_UNEXP_REQTYPE));
      flush_tracker();
      burst_head();
      c1_write(1'b0, WRLINE_M, CL_LEN_4, 2'd1, burst_addr(1), b_mdata, '0);
      c1_write(1'b1, WRLINE_M, CL_LEN_4, 2'd1, burst_addr(2), b_mdata, err_bit(C1_SOP_SET_MCL));
      flush_tracker();
      // Fence mid-burst, then the burst still completes
      burst_head();
      c1_write(1'b0, WRLINE_M, CL_LEN_4, 2'd1, burst_addr(1), b_mdata, '0);
      c1_write(1'b0, WRFENCE, CL_LEN_1, 2'd0, '0, '0, err_bit(C1_WRFENCE_IN_MCL));
      c1_write(1'b0, WRLINE_M, CL_LEN_4, 2'd1, burst_addr(2), b_mdata, '0);
      c1_write(1'b0, WRLINE_M, CL_LEN_4, 2'd1, burst_addr(3), b_mdata, '0);
      idle_cycle('0);
      end_test("c1_burst_errors");
   endtask

   task automatic test_c1_first_beat();
      logic [CL_ADDR_WIDTH-1:0] a;
      begin_test();
      c1_write(1'b0, WRLINE_I, CL_LEN_1, 2'd0, rand_addr(), rand_mdata(),
               err_bit(C1_SOP_NOT_SET));
      c1_write(1'b1, WRFENCE, CL_LEN_1, 2'd0, rand_addr(), '0, err_bit(C1_WRFENCE_SOP));
      a = rand_addr();
      a[1:0] = 2'b00;
      c1_write(1'b1, WRLINE_I, CL_LEN_3, 2'd0, a, rand_mdata(), err_bit(C1_3CL));
      a[1:0] = 2'b01;
      c1_write(1'b1, WRLINE_M, CL_LEN_4, 2'd0, a, rand_mdata(), err_bit(C1_ALIGN4));
      flush_tracker();
      c1_write(1'b1, t_c1_req'(4'h7), CL_LEN_1, 2'd0, rand_addr(), rand_mdata(),
               err_bit(C1_INVALID_REQTYPE));
      c1_realfull = 1'b1;
      c1_write(1'b1, WRLINE_I, CL_LEN_1, 2'd0, rand_addr(), rand_mdata(),
               err_bit(C1_OVERFLOW));
      end_test("c1_first_beat");
   endtask

   task automatic test_mmio();
      begin_test();
      // Answered within 8 cycles
      mmio_cycle(1'b1, 9'h011, 1'b0, '0, '0);
      repeat (6) idle_cycle('0);
      mmio_cycle(1'b0, '0, 1'b1, 9'h011, '0);
      idle_cycle('0);
      mmio_cycle(1'b0, '0, 1'b1, 9'h0a5, err_bit(MMIO_UNSOLICITED));
      // Unanswered, bit rises MMIO_TIMEOUT+1 edges after the request edge
      mmio_cycle(1'b1, 9'h133, 1'b0, '0, '0);
      for (int k = 1; k <= 20; k++) begin
         idle_cycle((k > tmo_cycles) ? err_bit(MMIO_TIMEOUT) : '0);
      end
      mmio_cycle(1'b0, '0, 1'b1, 9'h133, err_bit(MMIO_TIMEOUT));
      idle_cycle('0);
      idle_cycle('0);
      mmio_cycle(1'b1, 9'h0f0, 1'b0, '0, '0);
      soft_reset = 1'b1;
      mmio_cycle(1'b0, '0, 1'b1, 9'h0f0, err_bit(MMIO_RESET_IGNORED));
      idle_cycle('0);
      end_test("mmio");
   endtask

   // Watchdog
   initial begin
      #(clk_period * (test_cycles + margin_cycles));
      $display("Timeout: tests did not finish within %0d clock cycles",
               test_cycles + margin_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      seed           = 77;
      err_count      = 0;
      test_count     = 0;
      clk            = 1'b0;
      ase_reset      = 1'b1;
      soft_reset     = 1'b0;
      c0_valid       = 1'b0;
      c0_req_type    = RDLINE_I;
      c0_cl_len      = CL_LEN_1;
      c0_address     = '0;
      c0_realfull    = 1'b0;
      c1_valid       = 1'b0;
      c1_sop         = 1'b0;
      c1_req_type    = WRLINE_I;
      c1_cl_len      = CL_LEN_1;
      c1_vc_sel      = 2'd0;
      c1_address     = '0;
      c1_mdata       = '0;
      c1_realfull    = 1'b0;
      mmio_req_valid = 1'b0;
      mmio_req_tid   = '0;
      mmio_rsp_valid = 1'b0;
      mmio_rsp_tid   = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      ase_reset = 1'b0;
      check_vec("error_code", '0, error_code);
      test_c0_reads();
      test_c1_legal();
      test_c1_burst_errors();
      test_c1_first_beat();
      test_mmio();
      $display("%0d tests run, %0d errors", test_count, err_count);
      if (err_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== src.f ====
rtl/ccip_chk_pkg.sv
rtl/c0_read_checker.sv
rtl/c1_write_checker.sv
rtl/mmio_rsp_tracker.sv
rtl/ccip_checker_top.sv
tests/ccip_checker_sva.sv
tests/tb_ccip_checker.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CCI-P checker testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_ccip_checker -f src.f -o tb_sim
sim_out=$(./obj_dir/tb_sim 2>&1) || true
printf '%s\n' "$sim_out"
if printf '%s\n' "$sim_out" | grep -qx 'TEST RESULT: PASS'; then
   exit 0
fi
exit 1
